// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = soc_tb
FILE_LIST = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
+incdir+logic
logic/soc_bus_pkg.sv
logic/soc_periph_pkg.sv
logic/soc_bus.sv
logic/soc_ram.sv
logic/soc_mtimer.sv
logic/soc_gpio.sv
logic/soc_top.sv
sim/soc_tb.sv

// File: logic/soc_bus.sv
`timescale 1ns/1ns
`include "soc_params.svh"

module soc_bus import soc_bus_pkg::*; (
  input  logic      clock,
  input  logic      rst_n,
  // Manager side
  input  rw_addr_t  rw_address,
  input  logic      read_request,
  input  logic      write_request,
  output bus_data_t read_data,
  output logic      read_response,
  output logic      write_response,
  // Device side
  output logic      ram_read_request,
  output logic      ram_write_request,
  input  bus_data_t ram_read_data,
  input  logic      ram_read_response,
  input  logic      ram_write_response,
  output logic      mtimer_read_request,
  output logic      mtimer_write_request,
  input  bus_data_t mtimer_read_data,
  input  logic      mtimer_read_response,
  input  logic      mtimer_write_response,
  output logic      gpio_read_request,
  output logic      gpio_write_request,
  input  bus_data_t gpio_read_data,
  input  logic      gpio_read_response,
  input  logic      gpio_write_response
);

  device_sel_t sel;
  device_sel_t sel_q;
  logic        none_read_q;
  logic        none_write_q;
  logic [5:0]  dev_req;
  logic [5:0]  dev_rsp;

  // ------------------------------
  // Address decode
  // ------------------------------

  always_comb begin
    if ((rw_address - `RAM_BASE) < `RAM_SIZE) sel = DEV_RAM;
    else if ((rw_address - `MTIMER_BASE) < `PERIPH_SIZE) sel = DEV_MTIMER;
    else if ((rw_address - `GPIO_BASE) < `PERIPH_SIZE) sel = DEV_GPIO;
    else sel = DEV_NONE;
  end

  assign ram_read_request     = read_request  && (sel == DEV_RAM);
  assign ram_write_request    = write_request && (sel == DEV_RAM);
  assign mtimer_read_request  = read_request  && (sel == DEV_MTIMER);
  assign mtimer_write_request = write_request && (sel == DEV_MTIMER);
  assign gpio_read_request    = read_request  && (sel == DEV_GPIO);
  assign gpio_write_request   = write_request && (sel == DEV_GPIO);

  // Remember who owes the response next cycle
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      sel_q        <= DEV_NONE;
      none_read_q  <= 1'b0;
      none_write_q <= 1'b0;
    end else begin
      sel_q        <= (read_request || write_request) ? sel : DEV_NONE;
      none_read_q  <= read_request  && (sel == DEV_NONE);
      none_write_q <= write_request && (sel == DEV_NONE);
    end
  end

  // ------------------------------
  // Response mux
  // ------------------------------

  always_comb begin
    case (sel_q)
      DEV_RAM: begin
        read_data      = ram_read_data;
        read_response  = ram_read_response;
        write_response = ram_write_response;
      end
      DEV_MTIMER: begin
        read_data      = mtimer_read_data;
        read_response  = mtimer_read_response;
        write_response = mtimer_write_response;
      end
      DEV_GPIO: begin
        read_data      = gpio_read_data;
        read_response  = gpio_read_response;
        write_response = gpio_write_response;
      end
      default: begin
        // Unmapped requests are answered here with zero
        read_data      = '0;
        read_response  = none_read_q;
        write_response = none_write_q;
      end
    endcase
  end

  assign dev_req = {ram_read_request, ram_write_request, mtimer_read_request,
                    mtimer_write_request, gpio_read_request, gpio_write_request};
  assign dev_rsp = {ram_read_response, ram_write_response, mtimer_read_response,
                    mtimer_write_response, gpio_read_response, gpio_write_response};

  a_one_request_kind: assert property (@(posedge clock) disable iff (!rst_n)
    !(read_request && write_request));

  // Each device answers its own request exactly one cycle later
  a_device_latency: assert property (@(posedge clock) disable iff (!rst_n)
    dev_rsp == $past(dev_req));

endmodule

// File: logic/soc_bus_pkg.sv
package soc_bus_pkg;

  typedef logic [31:0] rw_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  wstrb_t;

  // Target of a request after address decode
  typedef enum logic [1:0] {
    DEV_NONE,
    DEV_RAM,
    DEV_MTIMER,
    DEV_GPIO
  } device_sel_t;

  // Expand byte strobes into a full word mask
  function automatic bus_data_t strobe_mask(wstrb_t strobe);
    bus_data_t mask;
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{strobe[b]}};
    end
    return mask;
  endfunction

  // Merge a write word into a register under the strobes
  function automatic bus_data_t apply_strobe(bus_data_t old_word, bus_data_t new_word,
                                             wstrb_t strobe);
    bus_data_t mask;
    mask = strobe_mask(strobe);
    return (old_word & ~mask) | (new_word & mask);
  endfunction

endpackage

// File: logic/soc_gpio.sv
`timescale 1ns/1ns
`include "soc_params.svh"

module soc_gpio import soc_bus_pkg::*, soc_periph_pkg::*; (
  input  logic      clock,
  input  logic      rst_n,
  input  rw_addr_t  rw_address,
  input  bus_data_t write_data,
  input  wstrb_t    write_strobe,
  input  logic      read_request,
  input  logic      write_request,
  output bus_data_t read_data,
  output logic      read_response,
  output logic      write_response,
  input  gpio_vec_t gpio_input,
  output gpio_vec_t gpio_oe,
  output gpio_vec_t gpio_output
);

  localparam reg_off_t OFF_IN  = 5'd0;
  localparam reg_off_t OFF_OE  = 5'd4;
  localparam reg_off_t OFF_OUT = 5'd8;
  localparam reg_off_t OFF_SET = 5'd12;
  localparam reg_off_t OFF_CLR = 5'd16;

  reg_off_t  offset;
  gpio_vec_t sync_q1;
  gpio_vec_t sync_q2;
  bus_data_t strobe_word;
  gpio_vec_t wmask;
  gpio_vec_t wbits;

  function automatic bus_data_t widen(gpio_vec_t v);
    bus_data_t w;
    w = '0;
    w[`GPIO_WIDTH-1:0] = v;
    return w;
  endfunction

  assign offset = rw_address[4:0];

  // Only the pin bits of the strobed write word
  assign strobe_word = strobe_mask(write_strobe);
  assign wmask       = strobe_word[`GPIO_WIDTH-1:0];
  assign wbits       = write_data[`GPIO_WIDTH-1:0] & wmask;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      sync_q1        <= '0;
      sync_q2        <= '0;
      gpio_oe        <= '0;
      gpio_output    <= '0;
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      // Two-flop input synchronizer
      sync_q1        <= gpio_input;
      sync_q2        <= sync_q1;
      read_response  <= read_request;
      write_response <= write_request;
      if (write_request) begin
        case (offset)
          OFF_OE:  gpio_oe     <= (gpio_oe & ~wmask) | wbits;
          OFF_OUT: gpio_output <= (gpio_output & ~wmask) | wbits;
          OFF_SET: gpio_output <= gpio_output | wbits;
          OFF_CLR: gpio_output <= gpio_output & ~wbits;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if (read_request) begin
      case (offset)
        OFF_IN:  read_data <= widen(sync_q2);
        OFF_OE:  read_data <= widen(gpio_oe);
        OFF_OUT: read_data <= widen(gpio_output);
        // Set and clear read as zero
        default: read_data <= '0;
      endcase
    end
  end

endmodule

// File: logic/soc_mtimer.sv
`timescale 1ns/1ns

module soc_mtimer import soc_bus_pkg::*, soc_periph_pkg::*; (
  input  logic      clock,
  input  logic      rst_n,
  input  rw_addr_t  rw_address,
  input  bus_data_t write_data,
  input  wstrb_t    write_strobe,
  input  logic      read_request,
  input  logic      write_request,
  output bus_data_t read_data,
  output logic      read_response,
  output logic      write_response,
  output logic      irq_timer
);

  localparam reg_off_t OFF_CTRL     = 5'd0;
  localparam reg_off_t OFF_MTIME_LO = 5'd4;
  localparam reg_off_t OFF_MTIME_HI = 5'd8;
  localparam reg_off_t OFF_CMP_LO   = 5'd12;
  localparam reg_off_t OFF_CMP_HI   = 5'd16;

  reg_off_t offset;
  logic     enable;
  mtime_t   mtime;
  mtime_t   mtimecmp;

  assign offset = rw_address[4:0];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      enable         <= 1'b0;
      mtime          <= '0;
      mtimecmp       <= '0;
      irq_timer      <= 1'b0;
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
      irq_timer      <= enable && (mtime >= mtimecmp);
      if (enable) mtime <= mtime + 64'd1;
      // A bus write to mtime wins over the increment
      if (write_request) begin
        case (offset)
          OFF_CTRL: if (write_strobe[0]) enable <= write_data[0];
          OFF_MTIME_LO:
            mtime <= {mtime[63:32], apply_strobe(mtime[31:0], write_data, write_strobe)};
          OFF_MTIME_HI:
            mtime <= {apply_strobe(mtime[63:32], write_data, write_strobe), mtime[31:0]};
          OFF_CMP_LO:
            mtimecmp <= {mtimecmp[63:32],
                         apply_strobe(mtimecmp[31:0], write_data, write_strobe)};
          OFF_CMP_HI:
            mtimecmp <= {apply_strobe(mtimecmp[63:32], write_data, write_strobe),
                         mtimecmp[31:0]};
          default: ;
        endcase
      end
    end
  end

  // Read mux
  always_ff @(posedge clock) begin
    if (read_request) begin
      case (offset)
        OFF_CTRL:     read_data <= {31'b0, enable};
        OFF_MTIME_LO: read_data <= mtime[31:0];
        OFF_MTIME_HI: read_data <= mtime[63:32];
        OFF_CMP_LO:   read_data <= mtimecmp[31:0];
        OFF_CMP_HI:   read_data <= mtimecmp[63:32];
        default:      read_data <= '0;
      endcase
    end
  end

endmodule

// File: logic/soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// ------------------------------
// Address map
// ------------------------------

`define RAM_BASE     32'h0000_0000
`define MTIMER_BASE  32'h8001_0000
`define GPIO_BASE    32'h8002_0000

// ------------------------------
// Region sizes in bytes
// ------------------------------

`define RAM_SIZE     32'd4096
`define PERIPH_SIZE  32'd32

// Number of GPIO pins
`define GPIO_WIDTH   8

`endif

// File: logic/soc_periph_pkg.sv
package soc_periph_pkg;

  `include "soc_params.svh"

  // Timer count and compare value
  typedef logic [63:0] mtime_t;

  // One bit per pin
  typedef logic [`GPIO_WIDTH-1:0] gpio_vec_t;

  // Byte offset inside a 32-byte device region
  typedef logic [4:0] reg_off_t;

endpackage

// File: logic/soc_ram.sv
`timescale 1ns/1ns
`include "soc_params.svh"

module soc_ram import soc_bus_pkg::*; (
  input  logic      clock,
  input  logic      rst_n,
  input  rw_addr_t  rw_address,
  input  bus_data_t write_data,
  input  wstrb_t    write_strobe,
  input  logic      read_request,
  input  logic      write_request,
  output bus_data_t read_data,
  output logic      read_response,
  output logic      write_response
);

  localparam int unsigned RAM_WORDS = `RAM_SIZE / 4;
  localparam int unsigned WORD_AW   = $clog2(RAM_WORDS);

  bus_data_t          mem [RAM_WORDS];
  logic [WORD_AW-1:0] word_idx;

  // Word index wraps inside the region
  assign word_idx = rw_address[WORD_AW+1:2];

  always_ff @(posedge clock) begin
    if (write_request) begin
      for (int b = 0; b < 4; b++) begin
        if (write_strobe[b]) mem[word_idx][8*b +: 8] <= write_data[8*b +: 8];
      end
    end
    if (read_request) read_data <= mem[word_idx];
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
    end
  end

  a_write_has_strobe: assert property (@(posedge clock) disable iff (!rst_n)
    write_request |-> (write_strobe != '0));

endmodule

// File: logic/soc_top.sv
`timescale 1ns/1ns

module soc_top import soc_bus_pkg::*, soc_periph_pkg::*; (
  input  logic      clock,
  input  logic      rst_n,
  input  rw_addr_t  rw_address,
  input  bus_data_t write_data,
  input  wstrb_t    write_strobe,
  input  logic      read_request,
  input  logic      write_request,
  output bus_data_t read_data,
  output logic      read_response,
  output logic      write_response,
  input  gpio_vec_t gpio_input,
  output gpio_vec_t gpio_oe,
  output gpio_vec_t gpio_output,
  output logic      irq_timer
);

  // ------------------------------
  // Bus to device wires
  // ------------------------------

  logic      ram_read_request;
  logic      ram_write_request;
  bus_data_t ram_read_data;
  logic      ram_read_response;
  logic      ram_write_response;

  logic      mtimer_read_request;
  logic      mtimer_write_request;
  bus_data_t mtimer_read_data;
  logic      mtimer_read_response;
  logic      mtimer_write_response;

  logic      gpio_read_request;
  logic      gpio_write_request;
  bus_data_t gpio_read_data;
  logic      gpio_read_response;
  logic      gpio_write_response;

  soc_bus bus_inst (
    .clock                 (clock),
    .rst_n                 (rst_n),
    .rw_address            (rw_address),
    .read_request          (read_request),
    .write_request         (write_request),
    .read_data             (read_data),
    .read_response         (read_response),
    .write_response        (write_response),
    .ram_read_request      (ram_read_request),
    .ram_write_request     (ram_write_request),
    .ram_read_data         (ram_read_data),
    .ram_read_response     (ram_read_response),
    .ram_write_response    (ram_write_response),
    .mtimer_read_request   (mtimer_read_request),
    .mtimer_write_request  (mtimer_write_request),
    .mtimer_read_data      (mtimer_read_data),
    .mtimer_read_response  (mtimer_read_response),
    .mtimer_write_response (mtimer_write_response),
    .gpio_read_request     (gpio_read_request),
    .gpio_write_request    (gpio_write_request),
    .gpio_read_data        (gpio_read_data),
    .gpio_read_response    (gpio_read_response),
    .gpio_write_response   (gpio_write_response)
  );

  soc_ram ram_inst (
    .clock          (clock),
    .rst_n          (rst_n),
    .rw_address     (rw_address),
    .write_data     (write_data),
    .write_strobe   (write_strobe),
    .read_request   (ram_read_request),
    .write_request  (ram_write_request),
    .read_data      (ram_read_data),
    .read_response  (ram_read_response),
    .write_response (ram_write_response)
  );

  soc_mtimer mtimer_inst (
    .clock          (clock),
    .rst_n          (rst_n),
    .rw_address     (rw_address),
    .write_data     (write_data),
    .write_strobe   (write_strobe),
    .read_request   (mtimer_read_request),
    .write_request  (mtimer_write_request),
    .read_data      (mtimer_read_data),
    .read_response  (mtimer_read_response),
    .write_response (mtimer_write_response),
    .irq_timer      (irq_timer)
  );

  soc_gpio gpio_inst (
    .clock          (clock),
    .rst_n          (rst_n),
    .rw_address     (rw_address),
    .write_data     (write_data),
    .write_strobe   (write_strobe),
    .read_request   (gpio_read_request),
    .write_request  (gpio_write_request),
    .read_data      (gpio_read_data),
    .read_response  (gpio_read_response),
    .write_response (gpio_write_response),
    .gpio_input     (gpio_input),
    .gpio_oe        (gpio_oe),
    .gpio_output    (gpio_output)
  );

endmodule

// File: sim/soc_tb.sv
`timescale 1ns/1ns
`include "soc_params.svh"

module soc_tb import soc_bus_pkg::*, soc_periph_pkg::*; ();

  logic      clock;
  logic      rst_n;
  rw_addr_t  rw_address;
  bus_data_t write_data;
  wstrb_t    write_strobe;
  logic      read_request;
  logic      write_request;
  bus_data_t read_data;
  logic      read_response;
  logic      write_response;
  gpio_vec_t gpio_input;
  gpio_vec_t gpio_oe;
  gpio_vec_t gpio_output;
  logic      irq_timer;

  // One trace entry per operation line
  byte       op_q [$];
  rw_addr_t  addr_q [$];
  bus_data_t data_q [$];
  wstrb_t    strb_q [$];
  bus_data_t exp_q [$];

  int     value_errors;
  int     response_errors;
  int     trace_errors;
  int     cycles;
  int     cycle_limit;
  integer seed;

  soc_top dut (
    .clock          (clock),
    .rst_n          (rst_n),
    .rw_address     (rw_address),
    .write_data     (write_data),
    .write_strobe   (write_strobe),
    .read_request   (read_request),
    .write_request  (write_request),
    .read_data      (read_data),
    .read_response  (read_response),
    .write_response (write_response),
    .gpio_input     (gpio_input),
    .gpio_oe        (gpio_oe),
    .gpio_output    (gpio_output),
    .irq_timer      (irq_timer)
  );

  always #4 clock = ~clock;

  // Run limit
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycles);
      $display("Errors: %0d value, %0d response, %0d trace",
               value_errors, response_errors, trace_errors);
      $display("Verification failed");
      $finish;
    end
  end

  // ------------------------------
  // Compare tasks
  // ------------------------------

  task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_gpio(input string name, input gpio_vec_t got, input gpio_vec_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_irq(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h, expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic expect_response(input logic seen, input string what);
    if (seen !== 1'b1) begin
      $display("No %s arrived one cycle after its request", what);
      response_errors++;
    end
  endtask

  // ------------------------------
  // Bus and pin helpers
  // ------------------------------

  task automatic bus_write(input rw_addr_t addr, input bus_data_t data, input wstrb_t strb);
    @(posedge clock);
    rw_address    <= addr;
    write_data    <= data;
    write_strobe  <= strb;
    write_request <= 1'b1;
    @(posedge clock);
    write_request <= 1'b0;
    @(negedge clock);
    expect_response(write_response, $sformatf("write response for %h", addr));
  endtask

  task automatic bus_read(input rw_addr_t addr, input bus_data_t exp);
    @(posedge clock);
    rw_address   <= addr;
    read_request <= 1'b1;
    @(posedge clock);
    read_request <= 1'b0;
    @(negedge clock);
    expect_response(read_response, $sformatf("read response for %h", addr));
    if (read_response) check_data($sformatf("read_data @%h", addr), read_data, exp);
  endtask

  task automatic drive_pins(input gpio_vec_t value);
    @(posedge clock);
    gpio_input <= value;
    // Two sync flops plus margin
    repeat (3) @(posedge clock);
  endtask

  task automatic wait_irq(input int bound, input logic level);
    int n;
    n = 0;
    @(negedge clock);
    while (irq_timer !== level && n < bound) begin
      @(negedge clock);
      n++;
    end
    check_irq("irq_timer", irq_timer, level);
  endtask

  // ------------------------------
  // Trace file
  // ------------------------------

  task automatic load_trace();
    int        fd;
    int        ch;
    byte       op;
    rw_addr_t  addr;
    bus_data_t data;
    wstrb_t    strb;
    bus_data_t expv;
    fd = $fopen("sim/soc_trace.txt", "r");
    if (fd == 0) begin
      $display("The trace file sim/soc_trace.txt could not be opened");
      trace_errors++;
    end else begin
      while (!$feof(fd)) begin
        if ($fscanf(fd, " %c", op) == 1) begin
          if (op == "#") begin
            // Skip the rest of a comment line
            ch = $fgetc(fd);
            while (ch != "\n" && ch != -1)
              ch = $fgetc(fd);
          end else if ($fscanf(fd, " %h %h %h %h", addr, data, strb, expv) == 4) begin
            op_q.push_back(op);
            addr_q.push_back(addr);
            data_q.push_back(data);
            strb_q.push_back(strb);
            exp_q.push_back(expv);
          end else begin
            $display("A trace line starting with '%c' could not be parsed", op);
            trace_errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic replay_trace();
    for (int i = 0; i < op_q.size(); i++) begin
      case (op_q[i])
        "W": bus_write(addr_q[i], data_q[i], strb_q[i]);
        "R": bus_read(addr_q[i], exp_q[i]);
        "P": drive_pins(data_q[i][`GPIO_WIDTH-1:0]);
        "Q": begin
          @(negedge clock);
          check_gpio("gpio_oe", gpio_oe, data_q[i][`GPIO_WIDTH-1:0]);
          check_gpio("gpio_output", gpio_output, exp_q[i][`GPIO_WIDTH-1:0]);
        end
        "I": wait_irq(data_q[i], exp_q[i][0]);
        default: begin
          $display("Trace entry %0d has the unknown operation '%c'", i, op_q[i]);
          trace_errors++;
        end
      endcase
    end
  endtask

  // ------------------------------
  // Back-to-back random RAM pass
  // ------------------------------

  task automatic random_ram_pass();
    rw_addr_t  addr_list [32];
    bus_data_t model [`RAM_SIZE/4];
    bus_data_t data;
    // One write per cycle with each response checked a cycle later
    for (int i = 0; i <= 32; i++) begin
      @(posedge clock);
      if (i < 32) begin
        addr_list[i] = `RAM_BASE + (rw_addr_t'($random(seed)) & (`RAM_SIZE - 32'd4));
        data = $random(seed);
        model[addr_list[i] >> 2] = data;
        rw_address    <= addr_list[i];
        write_data    <= data;
        write_strobe  <= 4'hf;
        write_request <= 1'b1;
      end else begin
        write_request <= 1'b0;
      end
      if (i > 0) begin
        @(negedge clock);
        expect_response(write_response, $sformatf("write response for %h", addr_list[i-1]));
      end
    end
    for (int i = 0; i <= 32; i++) begin
      @(posedge clock);
      if (i < 32) begin
        rw_address   <= addr_list[i];
        read_request <= 1'b1;
      end else begin
        read_request <= 1'b0;
      end
      if (i > 0) begin
        @(negedge clock);
        expect_response(read_response, $sformatf("read response for %h", addr_list[i-1]));
        if (read_response)
          check_data($sformatf("read_data @%h", addr_list[i-1]), read_data,
                     model[addr_list[i-1] >> 2]);
      end
    end
  endtask

  initial begin
    clock           = 1'b0;
    rst_n           = 1'b0;
    rw_address      = '0;
    write_data      = '0;
    write_strobe    = '0;
    read_request    = 1'b0;
    write_request   = 1'b0;
    gpio_input      = '0;
    value_errors    = 0;
    response_errors = 0;
    trace_errors    = 0;
    cycles          = 0;
    seed            = 88;
    cycle_limit     = 4 * 64 + 200;
    load_trace();
    cycle_limit = 8 * op_q.size() + 4 * 64 + 200;
    repeat (5) @(posedge clock);
    rst_n <= 1'b1;
    replay_trace();
    random_ram_pass();
    repeat (2) @(posedge clock);
    $display("Errors: %0d value, %0d response, %0d trace",
             value_errors, response_errors, trace_errors);
    if (value_errors + response_errors + trace_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: sim/soc_trace.txt
# Columns: op address data strobe expected, all but op in hex
# W write, R read and compare, P drive gpio_input with data, Q gpio_oe=data gpio_output=expected,
# I wait up to data cycles for irq_timer to equal expected
# After reset
Q 00000000 00000000 0 00000000
I 00000000 00000002 0 00000000
R 80010000 00000000 0 00000000
R 80010004 00000000 0 00000000
R 8001000c 00000000 0 00000000
R 80020000 00000000 0 00000000
R 80020004 00000000 0 00000000
R 80020008 00000000 0 00000000
# RAM byte strobes
W 00000000 11223344 f 00000000
W 00000000 aabbccdd 5 00000000
R 00000000 00000000 0 11bb33dd
W 00000ffc cafef00d f 00000000
W 00000ffc 00000000 2 00000000
R 00000ffc 00000000 0 cafe000d
# Unmapped addresses
R 40000000 00000000 0 00000000
W 00001000 deadbeef f 00000000
R 00000000 00000000 0 11bb33dd
# GPIO
W 80020004 000000ff f 00000000
W 80020008 000000a5 f 00000000
Q 00000000 000000ff 0 000000a5
W 8002000c 0000000a f 00000000
W 80020010 00000081 f 00000000
W 80020004 00000000 e 00000000
Q 00000000 000000ff 0 0000002e
R 8002000c 00000000 0 00000000
R 80020008 00000000 0 0000002e
P 00000000 0000003c 0 00000000
R 80020000 00000000 0 0000003c
# Timer
W 8001000c 00000014 f 00000000
W 80010010 00000000 f 00000000
W 80010004 00000000 f 00000000
W 80010008 00000000 f 00000000
R 8001000c 00000000 0 00000014
W 80010000 00000001 1 00000000
I 00000000 0000001e 0 00000001
W 80010010 00000001 f 00000000
I 00000000 00000004 0 00000000
R 80010010 00000000 0 00000001
R 80010000 00000000 0 00000001
